//--- build.f
led_panel_pkg.sv
framebuffer_ram.sv
timeout.sv
framebuffer_fetch.sv
panel_shifter.sv
scan_control.sv
led_panel_top.sv
led_panel_assertions.sv
tb_led_panel.sv

//--- Bender.yml
package:
  name: led_panel

sources:
  - led_panel_pkg.sv
  - framebuffer_ram.sv
  - timeout.sv
  - framebuffer_fetch.sv
  - panel_shifter.sv
  - scan_control.sv
  - led_panel_top.sv
  - target: test
    files:
      - led_panel_assertions.sv
      - tb_led_panel.sv

//--- tb_led_panel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_led_panel
    import led_panel_pkg::*;
;
    localparam int MAX_PASSES = 16;
    localparam int BASE_ON = 4;

    logic         clk_in;
    logic         reset;
    logic         wr_en;
    ram_address_t wr_address;
    rgb565_t      wr_data;
    panel_out_t   panel;

    rgb565_t   fb_model [2048];
    logic [31:0] lcg_state;
    int        errors;
    int        checks;
    int        tests_run;
    int        cycles;
    int        deadline;

    // panel model state, filled at each falling edge
    rgb_bits_t cap_top [64];
    rgb_bits_t cap_bottom [64];
    rgb_bits_t pass_top [MAX_PASSES][64];
    rgb_bits_t pass_bottom [MAX_PASSES][64];
    int        pass_shifts [MAX_PASSES];
    row_t      pass_row [MAX_PASSES];
    int        on_len [MAX_PASSES];
    bit        on_done [MAX_PASSES];
    int        shift_idx;
    int        pass_n;
    int        cur_len;
    bit        measuring;
    bit        row_moved;
    bit        early_oe_low;
    row_t      latched_row;

    led_panel_top #(
        .SHORT_FETCH   (1'b0),
        .BASE_ON_CYCLES(BASE_ON)
    ) i_dut (
        .clk_in    (clk_in),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_address(wr_address),
        .wr_data   (wr_data),
        .panel     (panel)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // roughly 8 cycles per column, blank, latch and the weighted on time
    function automatic int row_cycles();
        int total;
        total = 0;
        for (int p = 0; p < PLANE_COUNT; p++) begin
            total += 64 * 8 + 2 + (BASE_ON << p);
        end
        return total;
    endfunction

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles > deadline) begin
            $display("timeout, the scan did not reach the expected pass in time");
            $display("tests failed");
            $finish;
        end
    end

    always @(negedge clk_in) begin
        if (reset) begin
            shift_idx = 0;
            pass_n = 0;
            measuring = 1'b0;
            row_moved = 1'b0;
            early_oe_low = 1'b0;
            for (int i = 0; i < MAX_PASSES; i++) on_done[i] = 1'b0;
        end else begin
            if (pass_n == 0 && !panel.oe_n) early_oe_low = 1'b1;
            if (panel.panel_clk) begin
                if (shift_idx < 64) begin
                    cap_top[shift_idx] = panel.rgb_top;
                    cap_bottom[shift_idx] = panel.rgb_bottom;
                end
                shift_idx++;
            end
            if (panel.latch) begin
                if (pass_n < MAX_PASSES) begin
                    pass_top[pass_n] = cap_top;
                    pass_bottom[pass_n] = cap_bottom;
                    pass_shifts[pass_n] = shift_idx;
                    pass_row[pass_n] = panel.row;
                end
                shift_idx = 0;
                measuring = 1'b1;
                cur_len = 0;
                latched_row = panel.row;
                pass_n++;
            end else if (measuring) begin
                if (!panel.oe_n) begin
                    cur_len++;
                    if (panel.row != latched_row) row_moved = 1'b1;
                end else if (cur_len > 0) begin
                    if (pass_n <= MAX_PASSES) begin
                        on_len[pass_n-1] = cur_len;
                        on_done[pass_n-1] = 1'b1;
                    end
                    measuring = 1'b0;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // plane rule: bit plane of red, upper 5 green bits and blue
    function automatic rgb_bits_t expected_bits(input rgb565_t pix, input int plane);
        return {pix[11 + plane], pix[6 + plane], pix[plane]};
    endfunction

    task automatic check_rgb_bits(input string name, input rgb_bits_t exp, input rgb_bits_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic write_word(input ram_address_t a, input rgb565_t d);
        @(posedge clk_in);
        wr_en <= 1'b1;
        wr_address <= a;
        wr_data <= d;
        fb_model[a] = d;
    endtask

    // reload the whole framebuffer with the scan held in reset
    task automatic reload_frame(input bit distinct_row0);
        rgb565_t d;
        @(posedge clk_in);
        reset <= 1'b1;
        for (int a = 0; a < 2048; a++) begin
            lcg_state = lcg_next(lcg_state);
            d = lcg_state[31:16];
            if (distinct_row0 && a[9:6] == 4'd0) d = 16'(a * 16'h1f3b + 16'h0a51);
            write_word(ram_address_t'(a), d);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        reset <= 1'b0;
        deadline = cycles + 2 * 3 * row_cycles() + 2048;
    endtask

    task automatic wait_pass_done(input int p);
        while (!on_done[p]) @(posedge clk_in);
    endtask

    task automatic check_pass(input string name, input int p);
        int plane;
        int row;
        plane = p % PLANE_COUNT;
        row = p / PLANE_COUNT;
        check_count({name, " shifts"}, 64, pass_shifts[p]);
        check_count({name, " row"}, row, pass_row[p]);
        for (int k = 0; k < 64; k++) begin
            check_rgb_bits({name, " top"}, expected_bits(fb_model[{1'b0, row_t'(row),
                6'(63 - k)}], plane), pass_top[p][k]);
            check_rgb_bits({name, " bottom"}, expected_bits(fb_model[{1'b1, row_t'(row),
                6'(63 - k)}], plane), pass_bottom[p][k]);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "mismatches");
    endtask

    task automatic test_reset_state();
        int e;
        e = errors;
        @(negedge clk_in);
        check_count("reset oe_n", 1, panel.oe_n);
        check_count("reset latch", 0, panel.latch);
        check_count("reset panel_clk", 0, panel.panel_clk);
        check_rgb_bits("reset top", 3'b000, panel.rgb_top);
        check_rgb_bits("reset bottom", 3'b000, panel.rgb_bottom);
        wait_pass_done(0);
        check_count("reset first row", 0, pass_row[0]);
        check_count("reset oe_n before latch", 0, early_oe_low);
        finish_test("reset_state", e);
    endtask

    task automatic test_row0_plane0();
        int e;
        e = errors;
        reload_frame(1'b1);
        wait_pass_done(0);
        check_pass("row0_plane0", 0);
        finish_test("row0_plane0", e);
    endtask

    task automatic test_row0_planes();
        int e;
        e = errors;
        wait_pass_done(PLANE_COUNT - 1);
        for (int p = 0; p < PLANE_COUNT; p++) check_pass("row0_planes", p);
        finish_test("row0_planes", e);
    endtask

    task automatic test_lcg_rows();
        int e;
        e = errors;
        wait_pass_done(3 * PLANE_COUNT - 1);
        for (int p = 0; p < 3 * PLANE_COUNT; p++) check_pass("lcg_rows", p);
        finish_test("lcg_rows", e);
    endtask

    task automatic test_on_time();
        int e;
        e = errors;
        for (int p = 0; p < 3 * PLANE_COUNT; p++) begin
            check_count("on_time", BASE_ON << (p % PLANE_COUNT), on_len[p]);
            check_count("on_time row", p / PLANE_COUNT, pass_row[p]);
        end
        check_count("on_time row moved while lit", 0, row_moved);
        finish_test("on_time", e);
    endtask

    task automatic test_rewrite_row1();
        int e;
        e = errors;
        reload_frame(1'b0);
        while (pass_n < 1) @(posedge clk_in);
        // row 0 is displaying, rows are written well before row 1 fetches
        for (int a = 0; a < 128; a++) begin
            lcg_state = lcg_next(lcg_state);
            write_word({1'(a / 64), 4'd1, 6'(a % 64)}, lcg_state[31:16]);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        wait_pass_done(2 * PLANE_COUNT - 1);
        for (int p = PLANE_COUNT; p < 2 * PLANE_COUNT; p++) check_pass("rewrite_row1", p);
        finish_test("rewrite_row1", e);
    endtask

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        wr_address = '0;
        wr_data = '0;
        lcg_state = 32'h5a1a;
        errors = 0;
        checks = 0;
        tests_run = 0;
        cycles = 0;
        deadline = 2 * 3 * row_cycles();
        repeat (10) @(posedge clk_in);
        reset <= 1'b0;
        test_reset_state();
        test_row0_plane0();
        test_row0_planes();
        test_lcg_rows();
        test_on_time();
        test_rewrite_row1();
        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- led_panel_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module led_panel_assertions
    import led_panel_pkg::*;
(
    input wire logic       clk_in,
    input wire logic       reset,
    input wire panel_out_t panel
);

    // the row must be dark while its data is latched
    latch_dark: assert property (@(posedge clk_in) disable iff (reset)
        !(panel.latch && !panel.oe_n))
        else $error("latch high while oe_n is low");

    no_shift_in_latch: assert property (@(posedge clk_in) disable iff (reset)
        $rose(panel.panel_clk) |-> !panel.latch)
        else $error("panel_clk rose while latch is high");

    // one cycle clock pulse per shifted column
    clk_single_cycle: assert property (@(posedge clk_in) disable iff (reset)
        $rose(panel.panel_clk) |=> !panel.panel_clk)
        else $error("panel_clk pulse longer than one cycle");

endmodule

bind led_panel_top led_panel_assertions i_assertions (
    .clk_in(clk_in),
    .reset (reset),
    .panel (panel)
);

`default_nettype wire

//--- led_panel_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_panel_top
    import led_panel_pkg::*;
#(
    parameter bit SHORT_FETCH    = 1'b0,
    parameter int BASE_ON_CYCLES = 4
) (
    input  wire logic         clk_in,
    input  wire logic         reset,

    // host write port
    input  wire logic         wr_en,
    input  wire ram_address_t wr_address,
    input  wire rgb565_t      wr_data,

    output panel_out_t        panel
);

    ram_address_t ram_address;
    rgb565_t      ram_data;
    logic         ram_clk_enable;
    rgb565_t      rgb565_top;
    rgb565_t      rgb565_bottom;
    column_t      column_address;
    row_t         row_address;
    logic         pixel_load_start;
    plane_t       plane;
    logic         shift_strobe;
    rgb_bits_t    rgb_top;
    rgb_bits_t    rgb_bottom;
    logic         panel_clk;
    row_t         panel_row;
    logic         latch;
    logic         oe_n;

    framebuffer_ram i_framebuffer_ram (
        .clk_in    (clk_in),
        .wr_en     (wr_en),
        .wr_address(wr_address),
        .wr_data   (wr_data),
        .rd_enable (ram_clk_enable),
        .rd_address(ram_address),
        .rd_data   (ram_data)
    );

    framebuffer_fetch #(
        .SHORT_FETCH(SHORT_FETCH)
    ) i_framebuffer_fetch (
        .clk_in          (clk_in),
        .reset           (reset),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .ram_data_in     (ram_data),
        .ram_address     (ram_address),
        .ram_clk_enable  (ram_clk_enable),
        .rgb565_top      (rgb565_top),
        .rgb565_bottom   (rgb565_bottom)
    );

    panel_shifter i_panel_shifter (
        .clk_in       (clk_in),
        .reset        (reset),
        .rgb565_top   (rgb565_top),
        .rgb565_bottom(rgb565_bottom),
        .plane        (plane),
        .shift_strobe (shift_strobe),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom),
        .panel_clk    (panel_clk)
    );

    // the ram enable doubles as the fetch busy level
    scan_control #(
        .BASE_ON_CYCLES(BASE_ON_CYCLES)
    ) i_scan_control (
        .clk_in          (clk_in),
        .reset           (reset),
        .fetch_busy      (ram_clk_enable),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .plane           (plane),
        .shift_strobe    (shift_strobe),
        .panel_row       (panel_row),
        .latch           (latch),
        .oe_n            (oe_n)
    );

    assign panel = '{
        rgb_top:    rgb_top,
        rgb_bottom: rgb_bottom,
        row:        panel_row,
        panel_clk:  panel_clk,
        latch:      latch,
        oe_n:       oe_n
    };

endmodule

`default_nettype wire

//--- scan_control.sv
`timescale 1ns/1ps
`default_nettype none

module scan_control
    import led_panel_pkg::*;
#(
    parameter int BASE_ON_CYCLES = 4
) (
    input  wire logic clk_in,
    input  wire logic reset,

    // fetch side
    input  wire logic fetch_busy,
    output column_t   column_address,
    output row_t      row_address,
    output logic      pixel_load_start,

    // shifter side
    output plane_t    plane,
    output logic      shift_strobe,

    // panel control lines
    output row_t      panel_row,
    output logic      latch,
    output logic      oe_n
);

    // wide enough for the msb plane on-time
    localparam int ON_WIDTH = $clog2(BASE_ON_CYCLES << (PLANE_COUNT - 1)) + 1;

    scan_state_t         state;
    logic [ON_WIDTH-1:0] on_count;
    logic [ON_WIDTH-1:0] on_cycles;

    // binary weighted display time of the current plane
    assign on_cycles = ON_WIDTH'(BASE_ON_CYCLES) << plane;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state            <= SCAN_IDLE;
            column_address   <= '0;
            row_address      <= '0;
            plane            <= '0;
            panel_row        <= '0;
            pixel_load_start <= 1'b0;
            shift_strobe     <= 1'b0;
            latch            <= 1'b0;
            oe_n             <= 1'b1;
            on_count         <= '0;
        end else begin
            // strobes last a single cycle
            pixel_load_start <= 1'b0;
            shift_strobe     <= 1'b0;

            case (state)
                SCAN_IDLE: begin
                    state            <= SCAN_FETCH;
                    pixel_load_start <= 1'b1;
                end

                SCAN_FETCH: begin
                    // busy rises the cycle after the start pulse
                    if (!pixel_load_start && !fetch_busy) begin
                        state        <= SCAN_SHIFT;
                        shift_strobe <= 1'b1;
                    end
                end

                SCAN_SHIFT: begin
                    // wraps back to column 0 after the last shift
                    column_address <= column_address + 1'b1;
                    if (column_address == '1) begin
                        state <= SCAN_BLANK;
                    end else begin
                        state            <= SCAN_FETCH;
                        pixel_load_start <= 1'b1;
                    end
                end

                SCAN_BLANK: begin
                    // last panel_clk pulse is high during this cycle
                    state     <= SCAN_LATCH;
                    latch     <= 1'b1;
                    panel_row <= row_address;
                end

                SCAN_LATCH: begin
                    state    <= SCAN_DISPLAY;
                    latch    <= 1'b0;
                    oe_n     <= 1'b0;
                    on_count <= on_cycles - 1'b1;
                end

                SCAN_DISPLAY: begin
                    if (on_count == '0) begin
                        oe_n             <= 1'b1;
                        state            <= SCAN_FETCH;
                        pixel_load_start <= 1'b1;
                        // planes 0..4, then on to the next row
                        if (plane == plane_t'(PLANE_COUNT - 1)) begin
                            plane       <= '0;
                            row_address <= row_address + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        on_count <= on_count - 1'b1;
                    end
                end

                default: begin
                    state <= SCAN_IDLE;
                    oe_n  <= 1'b1;
                    latch <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- panel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module panel_shifter
    import led_panel_pkg::*;
(
    input  wire logic    clk_in,
    input  wire logic    reset,

    input  wire rgb565_t rgb565_top,
    input  wire rgb565_t rgb565_bottom,
    input  wire plane_t  plane,
    input  wire logic    shift_strobe,

    output rgb_bits_t    rgb_top,
    output rgb_bits_t    rgb_bottom,
    output logic         panel_clk
);

    // bit number plane of each 5-bit color field
    function automatic rgb_bits_t plane_bits(input rgb565_t pixel, input plane_t sel);
        logic [PLANE_COUNT-1:0] red;
        logic [PLANE_COUNT-1:0] green;
        logic [PLANE_COUNT-1:0] blue;
        red   = pixel[15:11];
        // drop the green lsb
        green = pixel[10:6];
        blue  = pixel[4:0];
        return {red[sel], green[sel], blue[sel]};
    endfunction

    // data and panel_clk change together, data then holds until the next strobe
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
            panel_clk  <= 1'b0;
        end else begin
            panel_clk <= shift_strobe;
            if (shift_strobe) begin
                rgb_top    <= plane_bits(rgb565_top, plane);
                rgb_bottom <= plane_bits(rgb565_bottom, plane);
            end
        end
    end

endmodule

`default_nettype wire

//--- framebuffer_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch
    import led_panel_pkg::*;
#(
    parameter bit SHORT_FETCH = 1'b0
) (
    input  wire logic         clk_in,
    input  wire logic         reset,

    input  wire column_t      column_address,
    input  wire row_t         row_address,

    input  wire logic         pixel_load_start,

    input  wire rgb565_t      ram_data_in,
    output ram_address_t      ram_address,
    output logic              ram_clk_enable,

    output rgb565_t           rgb565_top,
    output rgb565_t           rgb565_bottom
);

    // the long schedule spends one extra cycle before the top capture
    localparam int LOAD_VALUE = SHORT_FETCH ? 2 : 3;

    logic [1:0] pixel_load_counter;
    logic       half_address;

    assign ram_address = {half_address, row_address, ~column_address};

    timeout #(
        .COUNTER_WIDTH(2),
        .LOAD_VALUE   (LOAD_VALUE)
    ) i_timeout_pixel_load (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (pixel_load_start),
        .counter(pixel_load_counter),
        .running(ram_clk_enable)
    );

    // step the half bit on the falling edge, ahead of the next ram read
    //   first count  select half 0
    //   count 1      half 0 word is on ram_data_in, select half 1
    //   count 0      half 1 word is on ram_data_in
    always_ff @(negedge clk_in) begin
        if (reset) begin
            half_address <= 1'b0;
        end else if (ram_clk_enable) begin
            if (pixel_load_counter == 2'(LOAD_VALUE)) begin
                half_address <= 1'b0;
            end else if (pixel_load_counter == 2'd1) begin
                half_address <= 1'b1;
            end
        end
    end

    always_ff @(negedge clk_in) begin
        if (reset) begin
            rgb565_top    <= '0;
            rgb565_bottom <= '0;
        end else if (ram_clk_enable) begin
            if (pixel_load_counter == 2'd1) begin
                rgb565_top <= ram_data_in;
            end else if (pixel_load_counter == 2'd0) begin
                rgb565_bottom <= ram_data_in;
            end
        end
    end

endmodule

`default_nettype wire

//--- timeout.sv
`timescale 1ns/1ps
`default_nettype none

module timeout #(
    parameter int COUNTER_WIDTH = 2,
    parameter int LOAD_VALUE    = 3
) (
    input  wire logic                     clk_in,
    input  wire logic                     reset,
    input  wire logic                     start,
    output logic [COUNTER_WIDTH-1:0]      counter,
    output logic                          running
);

    // running stays high for LOAD_VALUE+1 cycles, counting LOAD_VALUE down to 0
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
            running <= 1'b0;
        end else if (start) begin
            // a start during a run restarts the count
            counter <= COUNTER_WIDTH'(LOAD_VALUE);
            running <= 1'b1;
        end else if (running) begin
            if (counter == '0) begin
                running <= 1'b0;
            end else begin
                counter <= counter - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- framebuffer_ram.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_ram
    import led_panel_pkg::*;
(
    input  wire logic         clk_in,

    // host write port
    input  wire logic         wr_en,
    input  wire ram_address_t wr_address,
    input  wire rgb565_t      wr_data,

    // display read port
    input  wire logic         rd_enable,
    input  wire ram_address_t rd_address,
    output rgb565_t           rd_data
);

    localparam int DEPTH = 2 ** $bits(ram_address_t);

    rgb565_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_address] <= wr_data;
        end
    end

    // registered read, output holds while the fetch is idle
    // a read of the word being written returns the old contents
    always_ff @(posedge clk_in) begin
        if (rd_enable) begin
            rd_data <= mem[rd_address];
        end
    end

endmodule

`default_nettype wire

//--- led_panel_pkg.sv
`default_nettype none

package led_panel_pkg;

    // one framebuffer word, red in 15..11, green in 10..5, blue in 4..0
    typedef logic [15:0] rgb565_t;

    // panel geometry, 64 columns and 16 scan rows per half
    typedef logic [5:0] column_t;
    typedef logic [3:0] row_t;

    // {half, row, ~column}
    typedef logic [10:0] ram_address_t;

    // bit plane index, plane 4 is the msb of each color
    typedef logic [2:0] plane_t;

    // red, green, blue bit of one pixel for one plane, red highest
    typedef logic [2:0] rgb_bits_t;

    // green keeps its upper 5 bits, so all colors have the same plane count
    localparam int PLANE_COUNT = 5;

    // lines to the HUB75 connector
    typedef struct packed {
        rgb_bits_t rgb_top;
        rgb_bits_t rgb_bottom;
        row_t      row;
        logic      panel_clk;
        logic      latch;
        logic      oe_n;
    } panel_out_t;

    // scan controller states
    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_FETCH,
        SCAN_SHIFT,
        SCAN_BLANK,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_t;

endpackage

`default_nettype wire
